// File: Makefile
# Verilator build and run of the PCIe TLP bridge testbench

VERILATOR ?= verilator
TOP       := tlp_bridge_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tlp_bridge_checker.sv
// Module tlp_bridge_checker and its bind: assertions on the core transmit and receive streams

module tlp_bridge_checker (
    input  logic                clk_pcie,
    input  logic                rst,
    input  tlps_pkg::core64_t   core_tx,
    input  logic                core_tx_ready,
    input  tlps_pkg::tlps128_t  rx_tlps,
    input  logic                app_ready,
    input  logic                static_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    import tlps_pkg::*;

    // --------------------
    // Transmit word
    // --------------------

    // Stalled word stays put
    tx_hold: assert property (@(posedge clk_pcie) disable iff (rst)
        core_tx.valid && !core_tx_ready |=>
            $stable(core_tx.data) && $stable(core_tx.keep) && $stable(core_tx.last))
        else $error("core transmit word changed while the core was stalled");

    tx_keep: assert property (@(posedge clk_pcie) disable iff (rst)
        core_tx.valid |-> (core_tx.keep == KEEP_QW || core_tx.keep == KEEP_DW))
        else $error("core transmit keep is neither a full nor a low double word");

    // Only one source may see ready
    one_ready: assert property (@(posedge clk_pcie) disable iff (rst)
        !(app_ready && static_ready))
        else $error("both sources saw ready in the same cycle");

    // --------------------
    // Reset
    // --------------------
    reset_quiet: assert property (@(posedge clk_pcie)
        rst |=> !core_tx.valid && !rx_tlps.valid && !app_ready && !static_ready)
        else $error("a valid or ready output was high under reset");

endmodule

bind pcie_tlp_bridge tlp_bridge_checker u_checker (
    .clk_pcie      (clk_pcie),
    .rst           (rst),
    .core_tx       (core_tx),
    .core_tx_ready (core_tx_ready),
    .rx_tlps       (rx_tlps),
    .app_ready     (app_ready),
    .static_ready  (static_ready)
);

// File: dv/tlp_bridge_tb.sv
// Module tlp_bridge_tb: packet table, source drivers, core loopback, stream checks and watchdog

module tlp_bridge_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import tlps_pkg::*;

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 8;
    localparam int ROWS         = 10;
    localparam int MAX_DWS      = 8;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + ROWS * 200) * PERIOD;

    typedef struct packed {
        logic       is_static;
        logic [3:0] ndw;
        logic [6:0] bar_hit;
    } row_t;

    // Columns: static source, double word count, BAR hit
    localparam row_t PKT_TABLE [ROWS] = '{
        '{1'b0, 4'd4, 7'h01}, '{1'b1, 4'd3, 7'h02}, '{1'b0, 4'd8, 7'h04},
        '{1'b1, 4'd1, 7'h08}, '{1'b0, 4'd5, 7'h10}, '{1'b0, 4'd2, 7'h20},
        '{1'b1, 4'd6, 7'h40}, '{1'b0, 4'd7, 7'h03}, '{1'b1, 4'd5, 7'h05},
        '{1'b1, 4'd8, 7'h06}
    };

    logic           clk_pcie      = 1'b0;
    logic           rst           = 1'b1;
    tlps128_t       app_tx        = '0;
    tlps128_t       static_tx     = '0;
    logic           core_tx_ready = 1'b0;
    core64_t        core_rx       = '0;
    core_rx_user_t  core_rx_user  = '0;
    logic           app_ready;
    logic           static_ready;
    core64_t        core_tx;
    tlps128_t       rx_tlps;

    integer         seed = 32'h794e;
    logic [31:0]    dw_mem [ROWS][MAX_DWS];
    int             pos [2];
    int             beat_idx [2];
    int             expect_row [2];
    logic           in_pkt = 1'b0;
    logic           both_at_grant = 1'b0;
    int             cur_row;
    int             word_idx;
    int             last_src;
    int             tx_done = 0;
    int             rx_done = 0;
    int             rx_beat = 0;
    int             rx_row_q [$];

    pcie_tlp_bridge u_dut (
        .clk_pcie      (clk_pcie),
        .rst           (rst),
        .app_tx        (app_tx),
        .static_tx     (static_tx),
        .core_tx_ready (core_tx_ready),
        .core_rx       (core_rx),
        .core_rx_user  (core_rx_user),
        .app_ready     (app_ready),
        .static_ready  (static_ready),
        .core_tx       (core_tx),
        .rx_tlps       (rx_tlps)
    );

    always #(PERIOD / 2) clk_pcie = ~clk_pcie;

    // --------------------
    // Helpers
    // --------------------
    task automatic abort_run(input string why);
        $display("Checks failed");
        $fatal(1, "%s", why);
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // First table row at or after from that belongs to source s
    function automatic int next_row(input int s, input int from);
        int r;
        r = from;
        while (r < ROWS && int'(PKT_TABLE[r].is_static) != s) begin
            r++;
        end
        return r;
    endfunction

    function automatic tlps128_t make_beat(input int r, input int b);
        tlps128_t t;
        int n;
        int i;
        t = '0;
        n = int'(PKT_TABLE[r].ndw) - 4 * b;
        if (n > 4) begin
            n = 4;
        end
        for (i = 0; i < n; i++) begin
            t.data.dw[2'(i)] = dw_mem[r][4 * b + i];
        end
        t.keep_dw      = 4'((1 << n) - 1);
        t.last         = (4 * b + n == int'(PKT_TABLE[r].ndw));
        t.valid        = 1'b1;
        t.user.first   = (b == 0);
        t.user.last    = t.last;
        t.user.bar_hit = PKT_TABLE[r].bar_hit;
        return t;
    endfunction

    // Step source s past an accepted beat and return what it presents next
    function automatic tlps128_t next_beat(input int s, input logic taken);
        if (taken) begin
            beat_idx[s]++;
            if (4 * beat_idx[s] >= int'(PKT_TABLE[pos[s]].ndw)) begin
                beat_idx[s] = 0;
                pos[s]      = next_row(s, pos[s] + 1);
            end
        end
        if (pos[s] < ROWS) begin
            return make_beat(pos[s], beat_idx[s]);
        end
        return '0;
    endfunction

    // Core word k of row r: double words in pairs, lower first
    function automatic core64_t tx_word(input int r, input int k);
        core64_t w;
        int ndw;
        ndw          = int'(PKT_TABLE[r].ndw);
        w            = '0;
        w.data[31:0] = dw_mem[r][2 * k];
        w.keep       = KEEP_DW;
        if (2 * k + 1 < ndw) begin
            w.data[63:32] = dw_mem[r][2 * k + 1];
            w.keep        = KEEP_QW;
        end
        w.last  = (2 * k + 2 >= ndw);
        w.valid = 1'b1;
        return w;
    endfunction

    task automatic check_rx_beat();
        int row;
        int n;
        int i;
        logic last_exp;
        if (rx_row_q.size() == 0) begin
            abort_run("Receive beat arrived with no packet sent");
        end else begin
            row = rx_row_q[0];
            n   = int'(PKT_TABLE[row].ndw) - 4 * rx_beat;
            if (n > 4) begin
                n = 4;
            end
            last_exp = (4 * rx_beat + n == int'(PKT_TABLE[row].ndw));
            compare("rx_tlps.keep_dw", 64'(rx_tlps.keep_dw), 64'((1 << n) - 1));
            for (i = 0; i < n; i++) begin
                compare("rx_tlps.data.dw", 64'(rx_tlps.data.dw[2'(i)]),
                        64'(dw_mem[row][4 * rx_beat + i]));
            end
            compare("rx_tlps.user.first", 64'(rx_tlps.user.first), 64'(rx_beat == 0));
            compare("rx_tlps.user.last", 64'(rx_tlps.user.last), 64'(last_exp));
            compare("rx_tlps.last", 64'(rx_tlps.last), 64'(last_exp));
            compare("rx_tlps.user.bar_hit", 64'(rx_tlps.user.bar_hit),
                    64'(PKT_TABLE[row].bar_hit));
            if (last_exp) begin
                void'(rx_row_q.pop_front());
                rx_beat = 0;
                rx_done++;
            end else begin
                rx_beat++;
            end
        end
    endtask

    // --------------------
    // Drivers
    // --------------------
    always @(posedge clk_pcie) begin
        core_tx_ready <= ($random(seed) & 3) != 0;
    end

    always @(posedge clk_pcie) begin
        if (rst) begin
            pos[0]      = next_row(0, 0);
            pos[1]      = next_row(1, 0);
            beat_idx[0] = 0;
            beat_idx[1] = 0;
            app_tx      <= '0;
            static_tx   <= '0;
        end else begin
            if (!app_tx.valid || app_ready) begin
                app_tx <= next_beat(0, app_ready);
            end
            if (!static_tx.valid || static_ready) begin
                static_tx <= next_beat(1, static_ready);
            end
        end
    end

    // --------------------
    // Monitor and loopback
    // --------------------
    always @(posedge clk_pcie) begin
        int tag;
        int src;
        core64_t exp_w;
        if (rst) begin
            expect_row[0] = next_row(0, 0);
            expect_row[1] = next_row(1, 0);
            last_src      = -1;
            in_pkt        = 1'b0;
            core_rx       <= '0;
            core_rx_user  <= '0;
        end else begin
            // Idle bus, the arbiter decides here
            if (!core_tx.valid) begin
                both_at_grant = app_tx.valid && static_tx.valid;
            end
            if (core_tx.valid && !in_pkt) begin
                tag = int'(core_tx.data[31:24]);
                if (tag >= ROWS) begin
                    abort_run("Core transmit word does not start any known packet");
                end else begin
                    src = int'(PKT_TABLE[tag].is_static);
                    compare("packet order", 64'(tag), 64'(expect_row[src]));
                    if (both_at_grant && last_src >= 0) begin
                        compare("granted source", 64'(src), 64'(1 - last_src));
                    end
                    expect_row[src] = next_row(src, tag + 1);
                    last_src        = src;
                    cur_row         = tag;
                    word_idx        = 0;
                    in_pkt          = 1'b1;
                    rx_row_q.push_back(tag);
                end
            end
            if (core_tx.valid && core_tx_ready) begin
                exp_w = tx_word(cur_row, word_idx);
                compare("core_tx.data", core_tx.data, exp_w.data);
                compare("core_tx.keep", 64'(core_tx.keep), 64'(exp_w.keep));
                compare("core_tx.last", 64'(core_tx.last), 64'(exp_w.last));
                core_rx              <= core_tx;
                core_rx_user.bar_hit <= PKT_TABLE[cur_row].bar_hit;
                word_idx++;
                if (exp_w.last) begin
                    in_pkt = 1'b0;
                    tx_done++;
                end
            end else begin
                core_rx.valid <= 1'b0;
            end
            if (rx_tlps.valid) begin
                check_rx_beat();
            end
        end
    end

    // --------------------
    // Main sequence and watchdog
    // --------------------
    initial begin
        int r;
        int i;
        for (r = 0; r < ROWS; r++) begin
            for (i = 0; i < MAX_DWS; i++) begin
                // Top byte tags the row
                dw_mem[r][i] = {8'(r), 24'($random(seed))};
            end
        end
        repeat (RESET_CYCLES) @(posedge clk_pcie);
        rst <= 1'b0;
        wait (rx_done == ROWS);
        repeat (4) @(posedge clk_pcie);
        if (tx_done == ROWS && rx_row_q.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            abort_run("Packet counts on transmit and receive do not match the table");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Watchdog expired before all packets came back on receive");
    end

endmodule

// File: source/pcie_tlp_bridge.sv
// Module pcie_tlp_bridge: top level joining transmit arbiter, downsizer and receive upsizer

module pcie_tlp_bridge (
    input  logic                    clk_pcie,
    input  logic                    rst,
    input  tlps_pkg::tlps128_t      app_tx,
    input  tlps_pkg::tlps128_t      static_tx,
    input  logic                    core_tx_ready,
    input  tlps_pkg::core64_t       core_rx,
    input  tlps_pkg::core_rx_user_t core_rx_user,
    output logic                    app_ready,
    output logic                    static_ready,
    output tlps_pkg::core64_t       core_tx,
    output tlps_pkg::tlps128_t      rx_tlps
);

    import tlps_pkg::*;

    // --------------------
    // Transmit path
    // --------------------
    tlps128_t   arb_tx;
    logic       dst_ready;

    tlps_tx_arbiter u_arbiter (
        .clk_pcie     (clk_pcie),
        .rst          (rst),
        .app_tx       (app_tx),
        .static_tx    (static_tx),
        .out_ready    (dst_ready),
        .app_ready    (app_ready),
        .static_ready (static_ready),
        .out_tx       (arb_tx)
    );

    tlps_dst64 u_dst64 (
        .clk_pcie      (clk_pcie),
        .rst           (rst),
        .tlps_in       (arb_tx),
        .core_tx_ready (core_tx_ready),
        .tlps_ready    (dst_ready),
        .core_tx       (core_tx)
    );

    // --------------------
    // Receive path
    // --------------------
    tlps_src64 u_src64 (
        .clk_pcie     (clk_pcie),
        .rst          (rst),
        .core_rx      (core_rx),
        .core_rx_user (core_rx_user),
        .rx_tlps      (rx_tlps)
    );

endmodule

// File: source/tlps_dst64.sv
// Module tlps_dst64: 128-bit transmit beat to 64-bit core word downsizer

module tlps_dst64 (
    input  logic                clk_pcie,
    input  logic                rst,
    input  tlps_pkg::tlps128_t  tlps_in,
    input  logic                core_tx_ready,
    output logic                tlps_ready,
    output tlps_pkg::core64_t   core_tx
);

    import tlps_pkg::*;

    // Set while the upper quad word of the beat is on the bus
    logic   upper;
    logic   final_word;
    logic   upper_dw_present;
    logic   word_taken;

    // Beat ends here when the upper half is out or there is no upper half
    assign final_word = upper || !tlps_in.keep_dw[2];

    // Second double word of the selected half
    assign upper_dw_present = upper ? tlps_in.keep_dw[3] : tlps_in.keep_dw[1];

    assign word_taken = tlps_in.valid && core_tx_ready;

    // --------------------
    // Core word
    // --------------------
    always_comb begin
        core_tx.data  = tlps_in.data.qw[upper];
        core_tx.keep  = upper_dw_present ? KEEP_QW : KEEP_DW;
        core_tx.last  = tlps_in.last && final_word;
        core_tx.valid = tlps_in.valid;
    end

    // Beat is consumed only with its final word
    assign tlps_ready = word_taken && final_word;

    // --------------------
    // Half select
    // --------------------
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            upper <= 1'b0;
        end else if (word_taken) begin
            // Lower half of a two-word beat moves to the upper half
            upper <= !final_word;
        end
    end

endmodule

// File: source/tlps_pkg.sv
// Package tlps_pkg: stream widths, keep constants, 128-bit beat union and stream structs

package tlps_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int DW_BITS      = 32;
    localparam int QW_BITS      = 64;
    localparam int BEAT_DWS     = 4;
    localparam int BAR_HIT_BITS = 7;

    // Core keep patterns, full word or low double word only
    localparam logic [7:0] KEEP_QW = 8'hff;
    localparam logic [7:0] KEEP_DW = 8'h0f;

    // --------------------
    // Stream types
    // --------------------

    // One 128-bit beat, seen as double words or as quad words
    typedef union packed {
        logic [BEAT_DWS-1:0][DW_BITS-1:0]   dw;
        logic [1:0][QW_BITS-1:0]            qw;
    } tlp_beat_u;

    typedef struct packed {
        logic [BAR_HIT_BITS-1:0]    bar_hit;
        logic                       last;
        logic                       first;
    } tlps_user_t;

    typedef struct packed {
        tlp_beat_u                  data;
        logic [BEAT_DWS-1:0]        keep_dw;
        logic                       last;
        logic                       valid;
        tlps_user_t                 user;
    } tlps128_t;

    // Core side word, used for both transmit and receive
    typedef struct packed {
        logic [QW_BITS-1:0]         data;
        logic [QW_BITS/8-1:0]       keep;
        logic                       last;
        logic                       valid;
    } core64_t;

    typedef struct packed {
        logic [BAR_HIT_BITS-1:0]    bar_hit;
    } core_rx_user_t;

endpackage

// File: source/tlps_src64.sv
// Module tlps_src64: 64-bit core receive word to 128-bit beat upsizer with sideband

module tlps_src64 (
    input  logic                    clk_pcie,
    input  logic                    rst,
    input  tlps_pkg::core64_t       core_rx,
    input  tlps_pkg::core_rx_user_t core_rx_user,
    output tlps_pkg::tlps128_t      rx_tlps
);

    import tlps_pkg::*;

    // --------------------
    // State
    // --------------------
    tlp_beat_u                  beat;
    logic                       first;
    logic                       tlast;
    logic [2:0]                 len;
    logic [BAR_HIT_BITS-1:0]    bar_hit;

    logic                       beat_valid;
    logic [2:0]                 next_base;
    logic [2:0]                 next_len;

    // Full once three or more double words are held, or the packet ended
    assign beat_valid = tlast || (len > 3'd2);

    // An emitted beat frees the buffer for the incoming word
    assign next_base = beat_valid ? 3'd0 : len;
    assign next_len  = next_base + 3'd1 + {2'b00, core_rx.keep[4]};

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            first <= 1'b1;
            tlast <= 1'b0;
            len   <= 3'd0;
        end else if (core_rx.valid) begin
            if (beat_valid) begin
                first <= tlast;
            end
            tlast <= core_rx.last;
            len   <= next_len;
        end else if (beat_valid) begin
            first <= tlast;
            tlast <= 1'b0;
            len   <= 3'd0;
        end
    end

    // Payload, written at the next double word offset
    always_ff @(posedge clk_pcie) begin
        if (core_rx.valid) begin
            beat.dw[next_base[1:0]]        <= core_rx.data[DW_BITS-1:0];
            beat.dw[next_base[1:0] + 2'd1] <= core_rx.data[2*DW_BITS-1:DW_BITS];
            bar_hit                        <= core_rx_user.bar_hit;
        end
    end

    // --------------------
    // Output beat
    // --------------------
    always_comb begin
        rx_tlps.data         = beat;
        rx_tlps.keep_dw      = {(len > 3'd3), (len > 3'd2), (len > 3'd1), 1'b1};
        rx_tlps.last         = tlast;
        rx_tlps.valid        = beat_valid;
        rx_tlps.user.first   = first;
        rx_tlps.user.last    = tlast;
        rx_tlps.user.bar_hit = bar_hit;
    end

endmodule

// File: source/tlps_tx_arbiter.sv
// Module tlps_tx_arbiter: packet-level round-robin arbiter of two 128-bit transmit streams

module tlps_tx_arbiter (
    input  logic                clk_pcie,
    input  logic                rst,
    input  tlps_pkg::tlps128_t  app_tx,
    input  tlps_pkg::tlps128_t  static_tx,
    input  logic                out_ready,
    output logic                app_ready,
    output logic                static_ready,
    output tlps_pkg::tlps128_t  out_tx
);

    import tlps_pkg::*;

    // Packet in progress, owner of the bus and previous owner
    logic       busy;
    logic       grant_static;
    logic       last_static;

    logic       pick_static;
    logic       pkt_done;
    tlps128_t   sel_tx;

    // --------------------
    // Grant decision
    // --------------------

    // Both asking: go to the one not served last
    always_comb begin
        if (app_tx.valid && static_tx.valid) begin
            pick_static = !last_static;
        end else begin
            pick_static = static_tx.valid;
        end
    end

    assign pkt_done = out_tx.valid && out_ready && out_tx.last;

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            busy         <= 1'b0;
            grant_static <= 1'b0;
            last_static  <= 1'b1;
        end else if (!busy) begin
            if (app_tx.valid || static_tx.valid) begin
                busy         <= 1'b1;
                grant_static <= pick_static;
            end
        end else if (pkt_done) begin
            // Release after the last beat goes through
            busy        <= 1'b0;
            last_static <= grant_static;
        end
    end

    // --------------------
    // Data mux
    // --------------------
    assign sel_tx = grant_static ? static_tx : app_tx;

    always_comb begin
        out_tx       = sel_tx;
        out_tx.valid = busy && sel_tx.valid;
    end

    // Ready follows the downstream only for the granted source
    assign app_ready    = out_ready && busy && !grant_static;
    assign static_ready = out_ready && busy && grant_static;

endmodule

// File: src.f
source/tlps_pkg.sv
source/tlps_tx_arbiter.sv
source/tlps_dst64.sv
source/tlps_src64.sv
source/pcie_tlp_bridge.sv
dv/tlp_bridge_checker.sv
dv/tlp_bridge_tb.sv
